// File: source/decode_pkg.sv
package decode_pkg;

    // ********************************************************
    // widths with a meaning
    // ********************************************************
    typedef logic [31:0] word_t;      // data word or address
    typedef logic [4:0]  reg_addr_t;  // gpr number
    typedef logic [5:0]  opcode_t;    // inst[31:26]
    typedef logic [5:0]  funct_t;     // inst[5:0], special only

    // one-hot, msb first: add sub slt sltu and nor or xor sll srl sra lui
    typedef logic [11:0] alu_ctrl_t;

    // ********************************************************
    // primary opcodes
    // ********************************************************
    localparam opcode_t OP_SPECIAL = 6'b000000;
    localparam opcode_t OP_REGIMM  = 6'b000001;  // bgez / bltz, told apart by rt
    localparam opcode_t OP_J       = 6'b000010;
    localparam opcode_t OP_JAL     = 6'b000011;
    localparam opcode_t OP_BEQ     = 6'b000100;
    localparam opcode_t OP_BNE     = 6'b000101;
    localparam opcode_t OP_BLEZ    = 6'b000110;
    localparam opcode_t OP_BGTZ    = 6'b000111;
    localparam opcode_t OP_ADDIU   = 6'b001001;
    localparam opcode_t OP_SLTI    = 6'b001010;
    localparam opcode_t OP_SLTIU   = 6'b001011;
    localparam opcode_t OP_ANDI    = 6'b001100;
    localparam opcode_t OP_ORI     = 6'b001101;
    localparam opcode_t OP_XORI    = 6'b001110;
    localparam opcode_t OP_LUI     = 6'b001111;
    localparam opcode_t OP_LW      = 6'b100011;
    localparam opcode_t OP_SW      = 6'b101011;

    // special function field
    localparam funct_t FN_SLL  = 6'b000000;
    localparam funct_t FN_SRL  = 6'b000010;
    localparam funct_t FN_SRA  = 6'b000011;
    localparam funct_t FN_SLLV = 6'b000100;
    localparam funct_t FN_SRLV = 6'b000110;
    localparam funct_t FN_SRAV = 6'b000111;
    localparam funct_t FN_JR   = 6'b001000;
    localparam funct_t FN_JALR = 6'b001001;
    localparam funct_t FN_ADDU = 6'b100001;
    localparam funct_t FN_SUBU = 6'b100011;
    localparam funct_t FN_AND  = 6'b100100;
    localparam funct_t FN_OR   = 6'b100101;
    localparam funct_t FN_XOR  = 6'b100110;
    localparam funct_t FN_NOR  = 6'b100111;
    localparam funct_t FN_SLT  = 6'b101010;
    localparam funct_t FN_SLTU = 6'b101011;

    localparam reg_addr_t LINK_REG    = 5'd31;
    localparam word_t     LINK_OFFSET = 32'd8;  // return past the delay slot

endpackage

// File: source/inst_decoder.sv
`timescale 1ns/1ps

module inst_decoder (
    input  decode_pkg::word_t     inst,
    output decode_pkg::reg_addr_t rs,
    output decode_pkg::reg_addr_t rt,
    output logic [4:0]            sa,
    output logic [15:0]           imm,
    output logic [25:0]           target,
    output decode_pkg::alu_ctrl_t alu_op,
    output logic                  shift_by_sa,
    output logic                  imm_zero_ext,
    output logic                  imm_sign_ext,
    output logic                  is_load,
    output logic                  is_store,
    output logic                  is_jr,
    output logic                  is_link,
    output logic                  is_jump,
    output logic                  is_jbr,
    output logic                  is_beq,
    output logic                  is_bne,
    output logic                  is_bgez,
    output logic                  is_bgtz,
    output logic                  is_blez,
    output logic                  is_bltz,
    output logic                  uses_rs,
    output logic                  uses_rt,
    output logic                  rf_wen,
    output decode_pkg::reg_addr_t rf_wdest
);
    import decode_pkg::*;

    opcode_t   op;
    funct_t    funct;
    reg_addr_t rd;
    logic      special;
    logic      sa_zero;
    logic      rs_zero;
    logic      rt_zero;
    logic      rd_zero;

    logic i_addu, i_subu, i_slt, i_sltu, i_and, i_nor, i_or, i_xor;
    logic i_sll, i_srl, i_sra, i_sllv, i_srlv, i_srav, i_jr, i_jalr;
    logic i_addiu, i_slti, i_sltiu, i_andi, i_ori, i_xori, i_lui;
    logic i_j, i_jal;
    logic r_var;     // r-type reading both rs and rt
    logic imm_alu;   // i-type alu reading rs
    logic branch;
    logic wdest_rt;
    logic wdest_31;
    logic wdest_rd;

    // field split
    assign op     = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign sa     = inst[10:6];
    assign funct  = inst[5:0];
    assign imm    = inst[15:0];
    assign target = inst[25:0];

    assign special = (op == OP_SPECIAL);
    assign sa_zero = (sa == 5'd0);
    assign rs_zero = (rs == 5'd0);
    assign rt_zero = (rt == 5'd0);
    assign rd_zero = (rd == 5'd0);

    // ********************************************************
    // recognition, unused fields must be zero
    // ********************************************************
    assign i_addu  = special & sa_zero & (funct == FN_ADDU);
    assign i_subu  = special & sa_zero & (funct == FN_SUBU);
    assign i_slt   = special & sa_zero & (funct == FN_SLT);
    assign i_sltu  = special & sa_zero & (funct == FN_SLTU);
    assign i_and   = special & sa_zero & (funct == FN_AND);
    assign i_nor   = special & sa_zero & (funct == FN_NOR);
    assign i_or    = special & sa_zero & (funct == FN_OR);
    assign i_xor   = special & sa_zero & (funct == FN_XOR);
    assign i_sllv  = special & sa_zero & (funct == FN_SLLV);
    assign i_srlv  = special & sa_zero & (funct == FN_SRLV);
    assign i_srav  = special & sa_zero & (funct == FN_SRAV);
    assign i_sll   = special & rs_zero & (funct == FN_SLL);  // all-zero nop lands here
    assign i_srl   = special & rs_zero & (funct == FN_SRL);
    assign i_sra   = special & rs_zero & (funct == FN_SRA);
    assign i_jr    = special & rt_zero & rd_zero & sa_zero & (funct == FN_JR);
    assign i_jalr  = special & rt_zero & sa_zero & (funct == FN_JALR);

    assign i_addiu = (op == OP_ADDIU);
    assign i_slti  = (op == OP_SLTI);
    assign i_sltiu = (op == OP_SLTIU);
    assign i_andi  = (op == OP_ANDI);
    assign i_ori   = (op == OP_ORI);
    assign i_xori  = (op == OP_XORI);
    assign i_lui   = (op == OP_LUI) & rs_zero;
    assign i_j     = (op == OP_J);
    assign i_jal   = (op == OP_JAL);
    assign is_load  = (op == OP_LW);
    assign is_store = (op == OP_SW);

    assign is_beq  = (op == OP_BEQ);
    assign is_bne  = (op == OP_BNE);
    assign is_bgez = (op == OP_REGIMM) & (rt == 5'd1);
    assign is_bltz = (op == OP_REGIMM) & rt_zero;
    assign is_bgtz = (op == OP_BGTZ) & rt_zero;
    assign is_blez = (op == OP_BLEZ) & rt_zero;

    // classes
    assign r_var   = i_addu | i_subu | i_slt | i_sltu | i_and | i_nor | i_or | i_xor
                   | i_sllv | i_srlv | i_srav;
    assign imm_alu = i_addiu | i_slti | i_sltiu | i_andi | i_ori | i_xori;
    assign branch  = is_beq | is_bne | is_bgez | is_bgtz | is_blez | is_bltz;

    assign shift_by_sa  = i_sll | i_srl | i_sra;
    assign imm_zero_ext = i_andi | i_ori | i_xori | i_lui;
    assign imm_sign_ext = i_addiu | i_slti | i_sltiu | is_load | is_store;

    assign is_jr   = i_jr | i_jalr;
    assign is_link = i_jal | i_jalr;
    assign is_jump = i_j | i_jal | is_jr;
    assign is_jbr  = is_jump | branch;

    // links get their add from exe_bundle
    assign alu_op = {i_addu | i_addiu | is_load | is_store,
                     i_subu,
                     i_slt | i_slti,
                     i_sltu | i_sltiu,
                     i_and | i_andi,
                     i_nor,
                     i_or | i_ori,
                     i_xor | i_xori,
                     i_sll | i_sllv,
                     i_srl | i_srlv,
                     i_sra | i_srav,
                     i_lui};

    // sources really read, drives the load-use check
    assign uses_rs = r_var | imm_alu | is_jr | is_load | is_store | branch;
    assign uses_rt = r_var | shift_by_sa | is_beq | is_bne | is_store;

    // destination select
    assign wdest_rt = imm_alu | i_lui | is_load;
    assign wdest_31 = i_jal;
    assign wdest_rd = r_var | shift_by_sa | i_jalr;
    assign rf_wen   = wdest_rt | wdest_31 | wdest_rd;
    assign rf_wdest = wdest_rt ? rt :
                      wdest_31 ? LINK_REG :
                      wdest_rd ? rd : 5'd0;  // 0 when nothing written

    always_comb begin
        assert ($onehot0(alu_op))
            else $error("alu_op has more than one operation set: %b", alu_op);
    end

endmodule

// File: source/operand_bypass.sv
`timescale 1ns/1ps

module operand_bypass (
    input  decode_pkg::reg_addr_t rs,
    input  decode_pkg::reg_addr_t rt,
    input  logic                  uses_rs,
    input  logic                  uses_rt,
    input  decode_pkg::word_t     rs_value,
    input  decode_pkg::word_t     rt_value,
    input  logic                  exe_valid,
    input  logic                  mem_valid,
    input  logic                  wb_valid,
    input  decode_pkg::reg_addr_t exe_wdest,
    input  decode_pkg::reg_addr_t mem_wdest,
    input  decode_pkg::reg_addr_t wb_wdest,
    input  decode_pkg::word_t     exe_result,
    input  decode_pkg::word_t     mem_result,
    input  decode_pkg::word_t     wb_result,
    input  logic                  exe_is_load,
    output decode_pkg::word_t     rs_fwd,
    output decode_pkg::word_t     rt_fwd,
    output logic                  stall
);
    import decode_pkg::*;

    logic exe_hits_rs;
    logic exe_hits_rt;

    // youngest producer wins, $0 always reads the file
    function automatic word_t fwd_pick(input reg_addr_t src, input word_t rf_val);
        if (src == 5'd0)
            fwd_pick = rf_val;
        else if (exe_valid && exe_wdest == src)
            fwd_pick = exe_result;
        else if (mem_valid && mem_wdest == src)
            fwd_pick = mem_result;
        else if (wb_valid && wb_wdest == src)
            fwd_pick = wb_result;
        else
            fwd_pick = rf_val;
    endfunction

    always_comb begin
        rs_fwd = fwd_pick(rs, rs_value);
        rt_fwd = fwd_pick(rt, rt_value);
    end

    // ********************************************************
    // load-use: exe result not ready until mem
    // ********************************************************
    assign exe_hits_rs = uses_rs & (rs == exe_wdest);
    assign exe_hits_rt = uses_rt & (rt == exe_wdest);
    assign stall       = exe_valid & exe_is_load & (exe_wdest != 5'd0)
                       & (exe_hits_rs | exe_hits_rt);

    // a stalled source is one that forwarding takes from execute
    always_comb begin
        assert (!stall || (exe_valid && ((exe_hits_rs && rs_fwd == exe_result)
                                      || (exe_hits_rt && rt_fwd == exe_result))))
            else $error("stall raised with no matching producer in execute");
    end

endmodule

// File: source/branch_unit.sv
`timescale 1ns/1ps

module branch_unit (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              id_valid,
    input  logic              if_over,
    input  decode_pkg::word_t pc,
    input  decode_pkg::word_t rs_fwd,
    input  decode_pkg::word_t rt_fwd,
    input  logic [15:0]       imm,
    input  logic [25:0]       target,
    input  logic              is_jump,
    input  logic              is_jr,
    input  logic              is_jbr,
    input  logic              is_beq,
    input  logic              is_bne,
    input  logic              is_bgez,
    input  logic              is_bgtz,
    input  logic              is_blez,
    input  logic              is_bltz,
    input  logic              stall,
    output logic              jbr_taken,
    output decode_pkg::word_t jbr_target,
    output logic              id_over
);
    import decode_pkg::*;

    word_t bd_pc;      // delay slot pc
    word_t j_target;
    word_t br_target;
    logic  rs_eq_rt;
    logic  rs_zero;
    logic  rs_neg;
    logic  br_taken;
    logic  if_over_q;  // fetch done, one edge late

    assign bd_pc = pc + 32'd4;

    // ********************************************************
    // condition and target
    // ********************************************************
    assign rs_eq_rt = (rs_fwd == rt_fwd);
    assign rs_zero  = (rs_fwd == 32'd0);
    assign rs_neg   = rs_fwd[31];

    assign br_taken = (is_beq & rs_eq_rt)
                    | (is_bne & ~rs_eq_rt)
                    | (is_bgez & ~rs_neg)
                    | (is_bgtz & ~rs_neg & ~rs_zero)
                    | (is_blez & (rs_neg | rs_zero))
                    | (is_bltz & rs_neg);

    assign j_target  = is_jr ? rs_fwd : {bd_pc[31:28], target, 2'b00};
    assign br_target = bd_pc + {{14{imm[15]}}, imm, 2'b00};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            if_over_q <= 1'b0;
        else
            if_over_q <= if_over;
    end

    // jumps wait until fetch has settled the delay slot
    assign id_over    = id_valid & ~stall & (~is_jbr | if_over_q);
    assign jbr_taken  = (is_jump | br_taken) & id_over;
    assign jbr_target = is_jump ? j_target : br_target;

    assert property (@(posedge clk) disable iff (!rst_n)
                     jbr_taken |-> id_over && $past(if_over))
        else $error("redirect issued before fetch finished");

endmodule

// File: source/exe_bundle.sv
`timescale 1ns/1ps

module exe_bundle (
    input  decode_pkg::word_t     pc,
    input  decode_pkg::word_t     rs_fwd,
    input  decode_pkg::word_t     rt_fwd,
    input  logic [4:0]            sa,
    input  logic [15:0]           imm,
    input  decode_pkg::alu_ctrl_t alu_op,
    input  logic                  shift_by_sa,
    input  logic                  imm_zero_ext,
    input  logic                  imm_sign_ext,
    input  logic                  is_link,
    input  logic                  is_load,
    input  logic                  is_store,
    output decode_pkg::alu_ctrl_t alu_control,
    output decode_pkg::word_t     alu_operand1,
    output decode_pkg::word_t     alu_operand2,
    output logic                  mem_load,
    output logic                  mem_store,
    output decode_pkg::word_t     store_data
);
    import decode_pkg::*;

    word_t imm_zx;
    word_t imm_sx;

    assign imm_zx = {16'd0, imm};
    assign imm_sx = {{16{imm[15]}}, imm};

    // link writes pc + 8 through the adder
    assign alu_control = alu_op | {is_link, 11'd0};

    assign alu_operand1 = is_link     ? pc :
                          shift_by_sa ? {27'd0, sa} : rs_fwd;

    assign alu_operand2 = is_link      ? LINK_OFFSET :
                          imm_zero_ext ? imm_zx :
                          imm_sign_ext ? imm_sx : rt_fwd;

    assign mem_load   = is_load;
    assign mem_store  = is_store;
    assign store_data = rt_fwd;  // word store only

endmodule

// File: source/decode_stage.sv
`timescale 1ns/1ps

module decode_stage (
    input  logic                  clk,
    input  logic                  rst_n,
    input  logic                  id_valid,
    input  logic                  if_over,
    input  decode_pkg::word_t     pc,
    input  decode_pkg::word_t     inst,
    input  decode_pkg::word_t     rs_value,
    input  decode_pkg::word_t     rt_value,
    input  logic                  exe_valid,
    input  logic                  mem_valid,
    input  logic                  wb_valid,
    input  decode_pkg::reg_addr_t exe_wdest,
    input  decode_pkg::reg_addr_t mem_wdest,
    input  decode_pkg::reg_addr_t wb_wdest,
    input  decode_pkg::word_t     exe_result,
    input  decode_pkg::word_t     mem_result,
    input  decode_pkg::word_t     wb_result,
    input  logic                  exe_is_load,
    output decode_pkg::reg_addr_t rs,
    output decode_pkg::reg_addr_t rt,
    output logic                  jbr_taken,
    output decode_pkg::word_t     jbr_target,
    output logic                  id_over,
    output decode_pkg::alu_ctrl_t alu_control,
    output decode_pkg::word_t     alu_operand1,
    output decode_pkg::word_t     alu_operand2,
    output logic                  mem_load,
    output logic                  mem_store,
    output decode_pkg::word_t     store_data,
    output logic                  rf_wen,
    output decode_pkg::reg_addr_t rf_wdest,
    output decode_pkg::word_t     ex_pc
);
    import decode_pkg::*;

    // ********************************************************
    // decoder to the other blocks, names match port names
    // ********************************************************
    logic [4:0]  sa;
    logic [15:0] imm;
    logic [25:0] target;
    alu_ctrl_t   alu_op;
    logic        shift_by_sa;
    logic        imm_zero_ext;
    logic        imm_sign_ext;
    logic        is_load;
    logic        is_store;
    logic        is_jr;
    logic        is_link;
    logic        is_jump;
    logic        is_jbr;
    logic        is_beq;
    logic        is_bne;
    logic        is_bgez;
    logic        is_bgtz;
    logic        is_blez;
    logic        is_bltz;
    logic        uses_rs;
    logic        uses_rt;
    word_t       rs_fwd;    // after forwarding
    word_t       rt_fwd;
    logic        stall;

    inst_decoder   i_inst_decoder (.*);
    operand_bypass i_operand_bypass (.*);
    branch_unit    i_branch_unit (.*);
    exe_bundle     i_exe_bundle (.*);

    assign ex_pc = pc;  // execute needs it for exceptions-free link and debug

endmodule

// File: tb/decode_vectors.svh
// columns of one row, stimulus first then expected values
// stages packs {exe_valid, exe_is_load, exe_wdest, mem_valid, mem_wdest, wb_valid, wb_wdest}
// rs_num and rt_num are the expected source register numbers
// flags packs {mem_load, mem_store, rf_wen, jbr_taken, id_over}
// srcs picks op1/op2/store_data: 0 literal, 1 exe, 2 mem, 3 wb result
typedef struct packed {
    word_t       pc;
    word_t       inst;
    word_t       rs_value;
    word_t       rt_value;
    logic [18:0] stages;
    logic        id_valid;
    logic        if_over;
    reg_addr_t   rs_num;
    reg_addr_t   rt_num;
    alu_ctrl_t   alu;
    word_t       op1;
    word_t       op2;
    word_t       sd;
    logic [4:0]  flags;
    reg_addr_t   wdest;
    word_t       target;    // checked only when taken
    logic [5:0]  srcs;
} vec_t;

vec_t rows[$];

localparam word_t       PC0 = 32'h0040_0100;
localparam word_t       PC1 = 32'hbfff_fffc;  // delay slot in the next 256 MB region
localparam word_t       VA  = 32'h1234_5678;
localparam word_t       VB  = 32'h0000_00f3;
localparam word_t       VN  = 32'hffff_fff0;  // negative rs
localparam logic [18:0] NOF = 19'd0;          // no later stage valid

function automatic word_t rtype(reg_addr_t s, reg_addr_t t, reg_addr_t d, logic [4:0] sa,
                                funct_t fn);
    return {OP_SPECIAL, s, t, d, sa, fn};
endfunction

function automatic word_t itype(opcode_t op, reg_addr_t s, reg_addr_t t, logic [15:0] imm);
    return {op, s, t, imm};
endfunction

function automatic logic [18:0] stages(logic ev, logic el, reg_addr_t ed, logic mv,
                                       reg_addr_t md, logic wv, reg_addr_t wd);
    return {ev, el, ed, mv, md, wv, wd};
endfunction

function automatic void add_row(word_t pc, word_t inst, word_t rsv, word_t rtv,
                                logic [18:0] stg, logic idv, logic ifo, reg_addr_t ers,
                                reg_addr_t ert, alu_ctrl_t alu, word_t op1, word_t op2,
                                word_t sd, logic [4:0] flags, reg_addr_t wd, word_t tgt,
                                logic [5:0] srcs);
    rows.push_back('{pc, inst, rsv, rtv, stg, idv, ifo, ers, ert, alu, op1, op2, sd, flags,
                     wd, tgt, srcs});
endfunction

// r-type on $2, $3 into $4
function automatic void rrow(funct_t fn, alu_ctrl_t alu);
    add_row(PC0, rtype(5'd2, 5'd3, 5'd4, 5'd0, fn), VA, VB, NOF, 1'b1, 1'b1, 5'd2, 5'd3,
            alu, VA, VB, VB, 5'b00101, 5'd4, 32'd0, 6'd0);
endfunction

// i-type alu reading $2 into $5
function automatic void irow(opcode_t op, logic [15:0] imm, alu_ctrl_t alu, word_t op2);
    add_row(PC0, itype(op, 5'd2, 5'd5, imm), VA, VB, NOF, 1'b1, 1'b1, 5'd2, 5'd5,
            alu, VA, op2, VB, 5'b00101, 5'd5, 32'd0, 6'd0);
endfunction

// branch on $2 with rt field t
function automatic void brow(opcode_t op, reg_addr_t t, logic [15:0] imm, word_t rsv,
                             word_t rtv, logic taken, word_t tgt);
    add_row(PC0, itype(op, 5'd2, t, imm), rsv, rtv, NOF, 1'b1, 1'b1, 5'd2, t,
            12'h000, rsv, rtv, rtv, {3'b000, taken, 1'b1}, 5'd0, tgt, 6'd0);
endfunction

task automatic build_table();
    rrow(FN_ADDU, 12'h800);
    rrow(FN_SUBU, 12'h400);
    rrow(FN_SLT,  12'h200);
    rrow(FN_SLTU, 12'h100);
    rrow(FN_AND,  12'h080);
    rrow(FN_NOR,  12'h040);
    rrow(FN_OR,   12'h020);
    rrow(FN_XOR,  12'h010);
    rrow(FN_SLLV, 12'h008);
    rrow(FN_SRLV, 12'h004);
    rrow(FN_SRAV, 12'h002);
    add_row(PC0, rtype(5'd0, 5'd3, 5'd4, 5'd5, FN_SLL), VA, VB, NOF, 1'b1, 1'b1,
            5'd0, 5'd3, 12'h008, 32'd5, VB, VB, 5'b00101, 5'd4, 32'd0, 6'd0);
    add_row(PC0, rtype(5'd0, 5'd3, 5'd4, 5'd7, FN_SRL), VA, VB, NOF, 1'b1, 1'b1,
            5'd0, 5'd3, 12'h004, 32'd7, VB, VB, 5'b00101, 5'd4, 32'd0, 6'd0);
    add_row(PC0, rtype(5'd0, 5'd3, 5'd4, 5'd31, FN_SRA), VA, VB, NOF, 1'b1, 1'b1,
            5'd0, 5'd3, 12'h002, 32'd31, VB, VB, 5'b00101, 5'd4, 32'd0, 6'd0);
    // immediates
    irow(OP_ANDI,  16'h8001, 12'h080, 32'h0000_8001);
    irow(OP_ORI,   16'h8001, 12'h020, 32'h0000_8001);
    irow(OP_XORI,  16'h8001, 12'h010, 32'h0000_8001);
    irow(OP_ADDIU, 16'hfff8, 12'h800, 32'hffff_fff8);
    irow(OP_SLTI,  16'h8001, 12'h200, 32'hffff_8001);
    irow(OP_SLTIU, 16'h8001, 12'h100, 32'hffff_8001);
    add_row(PC0, itype(OP_LUI, 5'd0, 5'd5, 16'h8001), VA, VB, NOF, 1'b1, 1'b1,
            5'd0, 5'd5, 12'h001, VA, 32'h0000_8001, VB, 5'b00101, 5'd5, 32'd0, 6'd0);
    add_row(PC0, itype(OP_LW, 5'd2, 5'd5, 16'h0010), VA, VB, NOF, 1'b1, 1'b1,
            5'd2, 5'd5, 12'h800, VA, 32'h0000_0010, VB, 5'b10101, 5'd5, 32'd0, 6'd0);
    add_row(PC0, itype(OP_SW, 5'd2, 5'd3, 16'hfffc), VA, VB, NOF, 1'b1, 1'b1,
            5'd2, 5'd3, 12'h800, VA, 32'hffff_fffc, VB, 5'b01001, 5'd0, 32'd0, 6'd0);
    // forwarding priority
    add_row(PC0, rtype(5'd2, 5'd3, 5'd4, 5'd0, FN_ADDU), VA, VB,
            stages(1'b1, 1'b0, 5'd2, 1'b1, 5'd2, 1'b1, 5'd3), 1'b1, 1'b1,
            5'd2, 5'd3, 12'h800, 32'd0, 32'd0, 32'd0, 5'b00101, 5'd4, 32'd0, 6'b01_11_11);
    add_row(PC0, rtype(5'd2, 5'd3, 5'd4, 5'd0, FN_ADDU), VA, VB,
            stages(1'b0, 1'b0, 5'd2, 1'b1, 5'd2, 1'b1, 5'd2), 1'b1, 1'b1,
            5'd2, 5'd3, 12'h800, 32'd0, VB, VB, 5'b00101, 5'd4, 32'd0, 6'b10_00_00);
    // $0 neither forwards nor stalls, even behind a load to $0
    add_row(PC0, rtype(5'd0, 5'd3, 5'd4, 5'd0, FN_ADDU), VA, VB,
            stages(1'b1, 1'b1, 5'd0, 1'b1, 5'd3, 1'b0, 5'd0), 1'b1, 1'b1,
            5'd0, 5'd3, 12'h800, VA, 32'd0, 32'd0, 5'b00101, 5'd4, 32'd0, 6'b00_10_10);
    // load-use
    add_row(PC0, rtype(5'd2, 5'd3, 5'd4, 5'd0, FN_ADDU), VA, VB,
            stages(1'b1, 1'b1, 5'd3, 1'b0, 5'd0, 1'b0, 5'd0), 1'b1, 1'b1,
            5'd2, 5'd3, 12'h800, VA, 32'd0, 32'd0, 5'b00100, 5'd4, 32'd0, 6'b00_01_01);
    add_row(PC0, itype(OP_ADDIU, 5'd2, 5'd3, 16'h0004), VA, VB,
            stages(1'b1, 1'b1, 5'd3, 1'b0, 5'd0, 1'b0, 5'd0), 1'b1, 1'b1,
            5'd2, 5'd3, 12'h800, VA, 32'd4, 32'd0, 5'b00101, 5'd3, 32'd0, 6'b00_00_01);
    add_row(PC0, itype(OP_BNE, 5'd2, 5'd3, 16'h0010), VA, VA,  // taken if not stalled
            stages(1'b1, 1'b1, 5'd2, 1'b0, 5'd0, 1'b0, 5'd0), 1'b1, 1'b1,
            5'd2, 5'd3, 12'h000, 32'd0, VA, VA, 5'b00000, 5'd0, 32'd0, 6'b01_00_00);
    // branches, delay slot at 0x00400104
    brow(OP_BEQ, 5'd3, 16'h0010, VA, VA, 1'b1, 32'h0040_0144);
    brow(OP_BEQ, 5'd3, 16'h0010, VA, VB, 1'b0, 32'd0);
    brow(OP_BNE, 5'd3, 16'hfffc, VA, VB, 1'b1, 32'h0040_00f4);
    brow(OP_BNE, 5'd3, 16'hfffc, VB, VB, 1'b0, 32'd0);
    brow(OP_REGIMM, 5'd1, 16'h0008, VA, VB, 1'b1, 32'h0040_0124);
    brow(OP_REGIMM, 5'd1, 16'h0008, VN, VB, 1'b0, 32'd0);
    brow(OP_REGIMM, 5'd0, 16'h0008, VA, VB, 1'b0, 32'd0);
    brow(OP_REGIMM, 5'd0, 16'h0008, VN, VB, 1'b1, 32'h0040_0124);
    brow(OP_BGTZ, 5'd0, 16'h0008, 32'd0, VB, 1'b0, 32'd0);
    brow(OP_BGTZ, 5'd0, 16'h0008, VA, VB, 1'b1, 32'h0040_0124);
    brow(OP_BLEZ, 5'd0, 16'h0008, 32'd0, VB, 1'b1, 32'h0040_0124);
    brow(OP_BLEZ, 5'd0, 16'h0008, VA, VB, 1'b0, 32'd0);
    // jumps
    add_row(PC1, {OP_J, 26'h010_0040}, VA, VB, NOF, 1'b1, 1'b1,
            5'd0, 5'd16, 12'h000, VA, VB, VB, 5'b00011, 5'd0, 32'hc040_0100, 6'd0);
    add_row(PC0, {OP_JAL, 26'h010_0040}, VA, VB, NOF, 1'b1, 1'b1,
            5'd0, 5'd16, 12'h800, PC0, 32'd8, VB, 5'b00111, 5'd31, 32'h0040_0100, 6'd0);
    add_row(PC0, rtype(5'd2, 5'd0, 5'd0, 5'd0, FN_JR), VA, VB, NOF, 1'b1, 1'b1,
            5'd2, 5'd0, 12'h000, VA, VB, VB, 5'b00011, 5'd0, VA, 6'd0);
    add_row(PC0, rtype(5'd2, 5'd0, 5'd9, 5'd0, FN_JALR), VA, VB, NOF, 1'b1, 1'b1,
            5'd2, 5'd0, 12'h800, PC0, 32'd8, VB, 5'b00111, 5'd9, VA, 6'd0);
    // fetch gating
    add_row(PC0, itype(OP_BEQ, 5'd2, 5'd3, 16'h0010), VA, VA, NOF, 1'b1, 1'b0,
            5'd2, 5'd3, 12'h000, VA, VA, VA, 5'b00000, 5'd0, 32'd0, 6'd0);
    add_row(PC0, rtype(5'd2, 5'd3, 5'd4, 5'd0, FN_ADDU), VA, VB, NOF, 1'b1, 1'b0,
            5'd2, 5'd3, 12'h800, VA, VB, VB, 5'b00101, 5'd4, 32'd0, 6'd0);
    add_row(PC0, rtype(5'd2, 5'd3, 5'd4, 5'd0, FN_ADDU), VA, VB, NOF, 1'b0, 1'b1,
            5'd2, 5'd3, 12'h800, VA, VB, VB, 5'b00100, 5'd4, 32'd0, 6'd0);
endtask

// File: tb/decode_stage_tb.sv
`timescale 1ns/1ps

module decode_stage_tb;
    import decode_pkg::*;

    logic      clk;
    logic      rst_n;
    logic      id_valid;
    logic      if_over;
    word_t     pc;
    word_t     inst;
    word_t     rs_value;
    word_t     rt_value;
    logic      exe_valid;
    logic      mem_valid;
    logic      wb_valid;
    reg_addr_t exe_wdest;
    reg_addr_t mem_wdest;
    reg_addr_t wb_wdest;
    word_t     exe_result;
    word_t     mem_result;
    word_t     wb_result;
    logic      exe_is_load;
    reg_addr_t rs;
    reg_addr_t rt;
    logic      jbr_taken;
    word_t     jbr_target;
    logic      id_over;
    alu_ctrl_t alu_control;
    word_t     alu_operand1;
    word_t     alu_operand2;
    logic      mem_load;
    logic      mem_store;
    word_t     store_data;
    logic      rf_wen;
    reg_addr_t rf_wdest;
    word_t     ex_pc;

    int    errors = 0;
    int    cycles = 0;
    int    limit  = 1000;
    word_t seed   = 32'hfa2b;

    `include "decode_vectors.svh"

    decode_stage i_dut (.*);

    always #2 clk = ~clk;

    // ************************************************************
    // helpers
    // ************************************************************
    function automatic word_t xorshift(input word_t x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic word_t pick(input logic [1:0] src, input word_t lit);
        case (src)
            2'd1:    return exe_result;
            2'd2:    return mem_result;
            2'd3:    return wb_result;
            default: return lit;
        endcase
    endfunction

    task automatic compare(input string name, input word_t got, input word_t exp);
        if (got !== exp) begin
            $display("Fail %0t: %s is %h, expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic check_row(input vec_t v);
        compare("rs", 32'(rs), 32'(v.rs_num));
        compare("rt", 32'(rt), 32'(v.rt_num));
        compare("alu_control", 32'(alu_control), 32'(v.alu));
        compare("alu_operand1", alu_operand1, pick(v.srcs[5:4], v.op1));
        compare("alu_operand2", alu_operand2, pick(v.srcs[3:2], v.op2));
        compare("store_data", store_data, pick(v.srcs[1:0], v.sd));
        compare("mem_load", 32'(mem_load), 32'(v.flags[4]));
        compare("mem_store", 32'(mem_store), 32'(v.flags[3]));
        compare("rf_wen", 32'(rf_wen), 32'(v.flags[2]));
        compare("jbr_taken", 32'(jbr_taken), 32'(v.flags[1]));
        compare("id_over", 32'(id_over), 32'(v.flags[0]));
        compare("rf_wdest", 32'(rf_wdest), 32'(v.wdest));
        compare("ex_pc", ex_pc, v.pc);
        if (v.flags[1])
            compare("jbr_target", jbr_target, v.target);
    endtask

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit) begin
            $display("run timed out after %0d cycles", cycles);
            $display("** FAIL **");
            $finish;
        end
    end

    // ************************************************************
    // main sequence
    // ************************************************************
    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        {id_valid, if_over, exe_valid, mem_valid, wb_valid, exe_is_load} = '0;
        {pc, inst, rs_value, rt_value} = '0;
        {exe_wdest, mem_wdest, wb_wdest} = '0;
        {exe_result, mem_result, wb_result} = '0;
        build_table();
        limit = 2 * rows.size() + 2 + 20;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            seed = xorshift(seed);
            exe_result <= seed;
            seed = xorshift(seed);
            mem_result <= seed;
            seed = xorshift(seed);
            wb_result <= seed;
            pc <= rows[i].pc;
            inst <= rows[i].inst;
            rs_value <= rows[i].rs_value;
            rt_value <= rows[i].rt_value;
            {exe_valid, exe_is_load, exe_wdest, mem_valid, mem_wdest, wb_valid, wb_wdest}
                <= rows[i].stages;
            id_valid <= rows[i].id_valid;
            if_over <= rows[i].if_over;
            @(posedge clk);  // if_over registered here
            @(negedge clk);
            check_row(rows[i]);
        end
        $display("rows %0d, errors %0d", rows.size(), errors);
        if (errors == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

// File: files.f
+incdir+tb
source/decode_pkg.sv
source/inst_decoder.sv
source/operand_bypass.sv
source/branch_unit.sv
source/exe_bundle.sv
source/decode_stage.sv
tb/decode_stage_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check for pass"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert -f files.f --top-module decode_stage_tb -Mdir obj_dir
	./obj_dir/Vdecode_stage_tb | tee sim.log
	grep -q "\*\* PASS \*\*" sim.log

clean:
	rm -rf obj_dir sim.log
